/* hdl/daf_design.sv */
// ~~~~~~~~~~~~~~~~~~~~
// audio effects top, serial stereo in and out
// receiver, frame FIFO and transmitter with effects
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module daf_design #(
  parameter int FIFO_DEPTH = daf_pkg::fifo_depth_default
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      serial_data_in,
  input  logic                      ws_in,
  input  logic [daf_pkg::en_fade:0] swch_mode_en,
  input  logic [daf_pkg::pot_w-1:0] pot_vol,
  input  logic [daf_pkg::pot_w-1:0] pot_amp_clp,
  input  logic [daf_pkg::pot_w-1:0] pot_amp_com,
  output logic                      serial_data_out,
  output logic                      ws_out
);

  // write side, receiver to FIFO
  logic            wr_cyc;
  logic            wr_stb;
  daf_pkg::frame_t wr_dat;
  logic            wr_ack;

  // read side, FIFO to transmitter
  logic            rd_cyc;
  logic            rd_stb;
  daf_pkg::frame_t rd_dat;
  logic            rd_ack;

  i2s_receiver rx0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .serial_data_in (serial_data_in),
    .ws_in          (ws_in),
    .wr_cyc         (wr_cyc),
    .wr_stb         (wr_stb),
    .wr_dat         (wr_dat),
    .wr_ack         (wr_ack)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_cyc (wr_cyc),
    .wr_stb (wr_stb),
    .wr_dat (wr_dat),
    .wr_ack (wr_ack),
    .rd_cyc (rd_cyc),
    .rd_stb (rd_stb),
    .rd_dat (rd_dat),
    .rd_ack (rd_ack)
  );

  i2s_transmitter tx0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .swch_mode_en    (swch_mode_en),
    .pot_vol         (pot_vol),
    .pot_amp_clp     (pot_amp_clp),
    .pot_amp_com     (pot_amp_com),
    .rd_cyc          (rd_cyc),
    .rd_stb          (rd_stb),
    .rd_dat          (rd_dat),
    .rd_ack          (rd_ack),
    .serial_data_out (serial_data_out),
    .ws_out          (ws_out)
  );

endmodule

/* hdl/daf_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// shared widths, the stereo frame word and effect constants
// referenced by scoped names from every design file
// ~~~~~~~~~~~~~~~~~~~~

package daf_pkg;

  // one signed audio sample, two's complement
  localparam int sample_w = 16;

  // left and right sample packed together
  localparam int frame_w = 2 * sample_w;

  // potentiometer setting width
  localparam int pot_w = 4;

  // left in the upper half, right in the lower half
  typedef struct packed {
    logic signed [sample_w-1:0] left;
    logic signed [sample_w-1:0] right;
  } stereo_t;

  // flat view for the serial side and the FIFO, channel view for the effects
  typedef union packed {
    logic [frame_w-1:0] word;
    stereo_t            ch;
  } frame_t;

  // clip limit and compression threshold are (pot + 1) * level_step - 1
  localparam int level_step = 2048;

  // bit positions in the mode enable
  localparam int en_clip = 0;
  localparam int en_comp = 1;
  localparam int en_fade = 2;

  // frames held in the sample FIFO, power of two
  localparam int fifo_depth_default = 4;

endpackage

/* hdl/effects_chain.sv */
// ~~~~~~~~~~~~~~~~~~~~
// two stage effects pipe, clip and compress then fade
// both channels handled alike, fixed latency of 2 cycles
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module effects_chain (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  daf_pkg::frame_t             in_frame,
  input  logic [daf_pkg::en_fade:0]   swch_mode_en,
  input  logic [daf_pkg::pot_w-1:0]   pot_vol,
  input  logic [daf_pkg::pot_w-1:0]   pot_amp_clp,
  input  logic [daf_pkg::pot_w-1:0]   pot_amp_com,
  output logic                        out_valid,
  output daf_pkg::frame_t             out_frame
);

  localparam int sw = daf_pkg::sample_w;
  // fade gain is vol / 16
  localparam int fade_shift = 4;

  // (pot + 1) * step - 1, always positive
  function automatic logic signed [sw-1:0] level(input logic [daf_pkg::pot_w-1:0] pot);
    int lv;
    lv = (int'(pot) + 1) * daf_pkg::level_step - 1;
    return lv[sw-1:0];
  endfunction

  function automatic logic signed [sw-1:0] clip(input logic signed [sw-1:0] x,
                                                input logic signed [sw-1:0] lim);
    if (x > lim) return lim;
    if (x < -lim) return -lim;
    return x;
  endfunction

  // work on magnitude so halving truncates toward zero
  function automatic logic signed [sw-1:0] compress(input logic signed [sw-1:0] x,
                                                    input logic signed [sw-1:0] thr);
    logic [sw:0] ext;
    logic [sw:0] mag;
    logic [sw:0] shaped;
    logic [sw:0] res;
    ext = {x[sw-1], x};
    // 17 bits so -32768 has a magnitude
    mag = ext[sw] ? (~ext + 1'b1) : ext;
    if (mag > {1'b0, thr}) shaped = {1'b0, thr} + ((mag - {1'b0, thr}) >> 1);
    else shaped = mag;
    res = ext[sw] ? (~shaped + 1'b1) : shaped;
    return res[sw-1:0];
  endfunction

  function automatic logic signed [sw-1:0] fade(input logic signed [sw-1:0] x,
                                                input logic [daf_pkg::pot_w-1:0] vol);
    logic signed [sw+daf_pkg::pot_w:0] prod;
    prod = (x * $signed({1'b0, vol})) >>> fade_shift;
    return prod[sw-1:0];
  endfunction

  logic            s1_valid;
  daf_pkg::frame_t s1_next;
  daf_pkg::frame_t s1_frame;
  daf_pkg::frame_t s2_next;

  // stage 1, clip before compress
  always_comb begin
    s1_next = in_frame;
    if (swch_mode_en[daf_pkg::en_clip]) begin
      s1_next.ch.left  = clip(s1_next.ch.left, level(pot_amp_clp));
      s1_next.ch.right = clip(s1_next.ch.right, level(pot_amp_clp));
    end
    if (swch_mode_en[daf_pkg::en_comp]) begin
      s1_next.ch.left  = compress(s1_next.ch.left, level(pot_amp_com));
      s1_next.ch.right = compress(s1_next.ch.right, level(pot_amp_com));
    end
  end

  // stage 2, volume
  always_comb begin
    s2_next = s1_frame;
    if (swch_mode_en[daf_pkg::en_fade]) begin
      s2_next.ch.left  = fade(s1_frame.ch.left, pot_vol);
      s2_next.ch.right = fade(s1_frame.ch.right, pot_vol);
    end
  end

  // valid rides with the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_frame  <= s1_next;
    out_frame <= s2_next;
  end

endmodule

/* hdl/i2s_receiver.sv */
// ~~~~~~~~~~~~~~~~~~~~
// serial stereo frame receiver, one bit per clk
// writes each finished frame to the sample FIFO as a Wishbone master
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module i2s_receiver (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            serial_data_in,
  input  logic            ws_in,
  output logic            wr_cyc,
  output logic            wr_stb,
  output daf_pkg::frame_t wr_dat,
  input  logic            wr_ack
);

  localparam int cnt_w = $clog2(daf_pkg::frame_w);

  logic             ws_q;
  logic             ws_fall;
  logic             busy;
  logic [cnt_w-1:0] bit_cnt;
  logic             last_bit;
  daf_pkg::frame_t  shift_q;
  daf_pkg::frame_t  hold_q;

  // frame starts on the falling word select, first bit on the same edge
  assign ws_fall = ws_q & ~ws_in;

  // bit_cnt holds the number of bits already taken
  assign last_bit = busy && (bit_cnt == cnt_w'(daf_pkg::frame_w - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // idle line has word select high
      ws_q    <= 1'b1;
      busy    <= 1'b0;
      bit_cnt <= '0;
    end else begin
      ws_q <= ws_in;
      if (ws_fall) begin
        busy    <= 1'b1;
        bit_cnt <= cnt_w'(1);
      end else if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        // 32nd bit sampled this edge
        if (last_bit) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // msb first, so shift in from the bottom
  always_ff @(posedge clk) begin
    if (ws_fall || busy) begin
      shift_q.word <= {shift_q.word[daf_pkg::frame_w-2:0], serial_data_in};
    end
    // holding register frees the shifter for the next frame
    if (last_bit) begin
      hold_q.word <= {shift_q.word[daf_pkg::frame_w-2:0], serial_data_in};
    end
  end

  // one write per frame, held until the FIFO acks
  // input and output share a bit rate, so the write is done long before the next frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_stb <= 1'b0;
    end else if (last_bit) begin
      wr_stb <= 1'b1;
    end else if (wr_ack) begin
      wr_stb <= 1'b0;
    end
  end

  // classic cycle, cyc and stb move together
  assign wr_cyc = wr_stb;
  assign wr_dat = hold_q;

endmodule

/* hdl/i2s_transmitter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// pulls frames from the FIFO, runs them through the effects
// and shifts them out back to back in the input format
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module i2s_transmitter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [daf_pkg::en_fade:0] swch_mode_en,
  input  logic [daf_pkg::pot_w-1:0] pot_vol,
  input  logic [daf_pkg::pot_w-1:0] pot_amp_clp,
  input  logic [daf_pkg::pot_w-1:0] pot_amp_com,
  output logic                      rd_cyc,
  output logic                      rd_stb,
  input  daf_pkg::frame_t           rd_dat,
  input  logic                      rd_ack,
  output logic                      serial_data_out,
  output logic                      ws_out
);

  localparam int fw    = daf_pkg::frame_w;
  localparam int cnt_w = $clog2(fw);

  logic             fetch;
  logic             slot_full;
  daf_pkg::frame_t  slot_q;
  logic             fx_valid;
  daf_pkg::frame_t  fx_frame;
  logic             tx_busy;
  logic [cnt_w-1:0] bit_cnt;
  logic [fw-1:0]    shift_q;
  logic             boundary;
  logic             load;

  effects_chain fx0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (rd_ack),
    .in_frame     (rd_dat),
    .swch_mode_en (swch_mode_en),
    .pot_vol      (pot_vol),
    .pot_amp_clp  (pot_amp_clp),
    .pot_amp_com  (pot_amp_com),
    .out_valid    (fx_valid),
    .out_frame    (fx_frame)
  );

  // fetch covers the bus request and the pipe until the slot fills
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_stb <= 1'b0;
      fetch  <= 1'b0;
    end else if (!fetch && !slot_full) begin
      rd_stb <= 1'b1;
      fetch  <= 1'b1;
    end else begin
      if (rd_ack) rd_stb <= 1'b0;
      if (fx_valid) fetch <= 1'b0;
    end
  end

  assign rd_cyc = rd_stb;

  // idle, or last right bit on the line this cycle
  assign boundary = !tx_busy || (bit_cnt == '0);
  assign load     = boundary && slot_full;

  // slot only refills after it was emptied, so fill and load never collide
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) slot_full <= 1'b0;
    else if (fx_valid) slot_full <= 1'b1;
    else if (load) slot_full <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (fx_valid) slot_q <= fx_frame;
    if (load) shift_q <= {slot_q.word[fw-2:0], 1'b0};
    else shift_q <= {shift_q[fw-2:0], 1'b0};
  end

  // bit_cnt is the bit number now leaving, wraps to 0 on the last one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy         <= 1'b0;
      bit_cnt         <= '0;
      ws_out          <= 1'b1;
      serial_data_out <= 1'b0;
    end else if (load) begin
      // ws falls with the left msb
      tx_busy         <= 1'b1;
      bit_cnt         <= cnt_w'(1);
      ws_out          <= 1'b0;
      serial_data_out <= slot_q.word[fw-1];
    end else if (boundary) begin
      tx_busy         <= 1'b0;
      ws_out          <= 1'b1;
      serial_data_out <= 1'b0;
    end else begin
      bit_cnt         <= bit_cnt + 1'b1;
      // upper half of the count is the right channel
      ws_out          <= bit_cnt[cnt_w-1];
      serial_data_out <= shift_q[fw-1];
    end
  end

endmodule

/* hdl/sample_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// frame FIFO between receiver and transmitter
// Wishbone slave on both sides, ack withheld while full or empty
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sample_fifo #(
  parameter int FIFO_DEPTH = daf_pkg::fifo_depth_default
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wr_cyc,
  input  logic            wr_stb,
  input  daf_pkg::frame_t wr_dat,
  output logic            wr_ack,
  input  logic            rd_cyc,
  input  logic            rd_stb,
  output daf_pkg::frame_t rd_dat,
  output logic            rd_ack
);

  localparam int aw = $clog2(FIFO_DEPTH);

  daf_pkg::frame_t mem [FIFO_DEPTH];

  // extra top bit tells full from empty when the addresses match
  logic [aw:0] wr_ptr;
  logic [aw:0] rd_ptr;
  logic        full;
  logic        empty;
  logic        wr_go;
  logic        rd_go;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

  // a strobe still high while its ack is out is the same request
  assign wr_go = wr_cyc & wr_stb & ~wr_ack & ~full;
  assign rd_go = rd_cyc & rd_stb & ~rd_ack & ~empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      wr_ack <= 1'b0;
      rd_ack <= 1'b0;
    end else begin
      // single cycle acks
      wr_ack <= wr_go;
      rd_ack <= rd_go;
      if (wr_go) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_go) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage and read data
  always_ff @(posedge clk) begin
    if (wr_go) begin
      mem[wr_ptr[aw-1:0]] <= wr_dat;
    end
    // data valid together with rd_ack
    if (rd_go) begin
      rd_dat <= mem[rd_ptr[aw-1:0]];
    end
  end

endmodule

/* run_sim.sh */
#!/bin/bash
# build with Verilator and run, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_daf_design -o sim_daf \
  || exit 1
out=$(./obj_dir/sim_daf)
echo "$out"
echo "$out" | grep -q "\*\*\* TEST PASSED \*\*\*" && exit 0 || exit 1

/* test/daf_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// watches the serial output, rebuilds frames from the ws_out fall
// and compares them with the expected frames queued by the testbench
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module daf_checker (
  input logic clk,
  input logic ws_out,
  input logic serial_data_out
);

  // expected frames in output order, with test number and last flag
  logic [31:0] exp_q[$];
  int          test_q[$];
  bit          last_q[$];

  int          errors = 0;
  int          checked = 0;
  int          test_frames = 0;
  int          test_errs = 0;

  logic        ws_prev = 1'b0;
  bit          active = 1'b0;
  int          cnt = 0;
  logic [31:0] sh = '0;

  task automatic add_expected(input logic [31:0] f, input int t, input bit last);
    exp_q.push_back(f);
    test_q.push_back(t);
    last_q.push_back(last);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic check_frame(input logic [31:0] got);
    logic [31:0] exp;
    int          t;
    bit          last;
    if (exp_q.size() == 0) begin
      $display("output frame %h at time %0t arrived with no expected value left", got, $time);
      errors++;
      return;
    end
    exp  = exp_q.pop_front();
    t    = test_q.pop_front();
    last = last_q.pop_front();
    checked++;
    test_frames++;
    if (got[31:16] !== exp[31:16]) begin
      $display("Mismatch at time %0t: test %0d left got %h expected %h",
               $time, t, got[31:16], exp[31:16]);
      errors++;
      test_errs++;
    end
    if (got[15:0] !== exp[15:0]) begin
      $display("Mismatch at time %0t: test %0d right got %h expected %h",
               $time, t, got[15:0], exp[15:0]);
      errors++;
      test_errs++;
    end
    if (last) begin
      $display("test %0d finished: %0d frames, %0d errors", t, test_frames, test_errs);
      test_frames = 0;
      test_errs   = 0;
    end
  endtask

  // outputs move on the rising edge, sample on the falling one
  always @(negedge clk) begin
    if (!active && ws_prev === 1'b1 && ws_out === 1'b0) begin
      active = 1'b1;
      cnt    = 1;
      sh     = {31'b0, serial_data_out};
    end else if (active) begin
      // ws_out low for bits 0 to 15 and high for 16 to 31
      if (ws_out !== (cnt >= 16)) begin
        $display("Mismatch at time %0t: ws_out is %b at bit %0d of the frame",
                 $time, ws_out, cnt);
        errors++;
        test_errs++;
      end
      sh  = {sh[30:0], serial_data_out};
      cnt = cnt + 1;
      // all 32 bits taken
      if (cnt == 32) begin
        active = 1'b0;
        check_frame(sh);
      end
    end
    ws_prev = ws_out;
  end

endmodule

/* test/daf_input.txt */
# test mode vol clp com in_left in_right exp_left exp_right, all hex
# mode bits: 0 clip, 1 compress, 2 fade
1 0 0 0 0 1234 abcd 1234 abcd
1 0 0 0 0 8000 7fff 8000 7fff
1 0 0 0 0 0000 ffff 0000 ffff
2 1 0 1 0 2000 e000 0fff f001
2 1 0 1 0 0800 f800 0800 f800
2 1 0 1 0 7fff 8000 0fff f001
3 2 0 0 3 3000 d000 27ff d801
3 2 0 0 3 1000 2001 1000 2000
3 2 0 0 3 7fff 8000 4fff b001
4 4 8 0 0 1000 f000 0800 f800
4 4 8 0 0 0001 ffff 0000 ffff
5 4 0 0 0 1234 8000 0000 0000
6 7 c 3 1 4000 c000 11ff ee00
6 7 c 3 1 0800 1001 0600 0c00
7 0 0 0 0 0001 0002 0001 0002
7 0 0 0 0 5a5a a5a5 5a5a a5a5
7 0 0 0 0 ffff 0000 ffff 0000
7 0 0 0 0 0f0f f0f0 0f0f f0f0
7 0 0 0 0 1111 2222 1111 2222
7 0 0 0 0 3333 4444 3333 4444
7 0 0 0 0 8001 7ffe 8001 7ffe
7 0 0 0 0 c3c3 3c3c c3c3 3c3c

/* test/tb_daf_design.sv */
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the audio effects top, frames read from the input file
// serialized with random idle gaps, checked by daf_checker
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_daf_design;

  logic        clk;
  logic        rst_n;
  logic        serial_data_in;
  logic        ws_in;
  logic [2:0]  swch_mode_en;
  logic [3:0]  pot_vol;
  logic [3:0]  pot_amp_clp;
  logic [3:0]  pot_amp_com;
  logic        serial_data_out;
  logic        ws_out;

  // one entry per frame line of the file
  int          t_num[64];
  logic [3:0]  t_mode[64];
  logic [3:0]  t_vol[64];
  logic [3:0]  t_clp[64];
  logic [3:0]  t_com[64];
  logic [15:0] in_l[64];
  logic [15:0] in_r[64];
  logic [15:0] exp_l[64];
  logic [15:0] exp_r[64];
  int          n_vec = 0;
  int          n_tests = 0;
  int          limit = 0;
  int          cycles = 0;
  int          high_run = 0;
  logic [31:0] lcg_state;

  daf_design dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .serial_data_in  (serial_data_in),
    .ws_in           (ws_in),
    .swch_mode_en    (swch_mode_en),
    .pot_vol         (pot_vol),
    .pot_amp_clp     (pot_amp_clp),
    .pot_amp_com     (pot_amp_com),
    .serial_data_out (serial_data_out),
    .ws_out          (ws_out)
  );

  daf_checker chk0 (
    .clk             (clk),
    .ws_out          (ws_out),
    .serial_data_out (serial_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // consecutive cycles with ws_out high
  always @(posedge clk) begin
    if (ws_out === 1'b1) high_run <= high_run + 1;
    else high_run <= 0;
  end

  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // lines starting with # are comments
  task automatic read_vectors();
    int    fd;
    int    n;
    string line;
    fd = $fopen("test/daf_input.txt", "r");
    if (fd == 0) begin
      $display("could not open test/daf_input.txt");
      return;
    end
    while (!$feof(fd) && n_vec < 64) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", t_num[n_vec], t_mode[n_vec],
                  t_vol[n_vec], t_clp[n_vec], t_com[n_vec], in_l[n_vec], in_r[n_vec],
                  exp_l[n_vec], exp_r[n_vec]);
      if (n == 9) begin
        if (n_vec == 0 || t_num[n_vec] != t_num[n_vec-1]) n_tests++;
        n_vec++;
      end
    end
    $fclose(fd);
  endtask

  // LCG picks an idle gap of 0 to 3 cycles
  function automatic int next_gap();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[17:16]);
  endfunction

  // drained once every queued frame is out and ws_out has idled 40 cycles
  task automatic wait_drain();
    while (chk0.pending() != 0 || high_run < 40) @(negedge clk);
  endtask

  // ws low for left and high for right, msb first
  task automatic send_frame(input logic [31:0] f);
    for (int b = 0; b < 32; b++) begin
      @(negedge clk);
      ws_in          = (b >= 16);
      serial_data_in = f[31-b];
    end
  endtask

  initial begin
    int  gap;
    bit  last;
    rst_n          = 1'b0;
    serial_data_in = 1'b0;
    ws_in          = 1'b1;
    swch_mode_en   = '0;
    pot_vol        = '0;
    pot_amp_clp    = '0;
    pot_amp_com    = '0;
    lcg_state      = 32'd78;
    read_vectors();
    if (n_vec == 0) begin
      $display("no test vectors were read");
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      limit = n_vec * 36 + n_tests * 120 + 200;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < n_vec; i++) begin
        // controls only move on a quiet output
        if (i == 0 || t_num[i] != t_num[i-1]) begin
          wait_drain();
          swch_mode_en = t_mode[i][2:0];
          pot_vol      = t_vol[i];
          pot_amp_clp  = t_clp[i];
          pot_amp_com  = t_com[i];
        end
        last = (i == n_vec - 1) || (t_num[i+1] != t_num[i]);
        chk0.add_expected({exp_l[i], exp_r[i]}, t_num[i], last);
        gap = next_gap();
        repeat (gap) begin
          @(negedge clk);
          ws_in          = 1'b1;
          serial_data_in = 1'b0;
        end
        send_frame({in_l[i], in_r[i]});
      end
      @(negedge clk);
      ws_in          = 1'b1;
      serial_data_in = 1'b0;
      wait_drain();
      $display("frames checked %0d of %0d, errors %0d", chk0.checked, n_vec, chk0.errors);
      if (chk0.errors == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

endmodule

/* vlog.f */
hdl/daf_pkg.sv
hdl/i2s_receiver.sv
hdl/sample_fifo.sv
hdl/effects_chain.sv
hdl/i2s_transmitter.sv
hdl/daf_design.sv
test/daf_checker.sv
test/tb_daf_design.sv
